// ==== load_isa_pkg.sv ====
// RV64 load ISA package with the data path widths, load operation encoding and size helpers
package load_isa_pkg;

    // --------------------
    // data path widths
    // --------------------

    // the integer register width of the RV64 core
    localparam int unsigned XLEN          = 64;
    localparam int unsigned XLEN_BYTES    = XLEN / 8;
    // byte position inside one data word
    localparam int unsigned OFFSET_W      = $clog2(XLEN_BYTES);
    // the store hazard check only looks at the offset inside a 4 KiB page
    localparam int unsigned PAGE_OFFSET_W = 12;

    // --------------------
    // load operations
    // --------------------

    // signed and unsigned variants for every size below a doubleword
    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_BU = 3'd1,
        LD_H  = 3'd2,
        LD_HU = 3'd3,
        LD_W  = 3'd4,
        LD_WU = 3'd5,
        LD_D  = 3'd6
    } ld_op_t;

    // byte lanes touched by an operation when the offset is zero
    function automatic logic [XLEN_BYTES-1:0] ld_lane_mask(ld_op_t op);
        case (op)
            LD_B, LD_BU: return 8'h01;
            LD_H, LD_HU: return 8'h03;
            LD_W, LD_WU: return 8'h0f;
            default:     return 8'hff;
        endcase
    endfunction

    // only the three sub-word signed loads replicate their top bit
    function automatic logic ld_is_signed(ld_op_t op);
        return op inside {LD_B, LD_H, LD_W};
    endfunction

endpackage

// ==== load_unit_pkg.sv ====
// Load unit package with the bus address configuration and the payloads between pipeline stages
package load_unit_pkg;

    import load_isa_pkg::*;

    // --------------------
    // configuration
    // --------------------

    // byte address width seen on the request port
    localparam int unsigned ADDR_W     = 32;
    // width of the tag that identifies a load in the scoreboard
    localparam int unsigned TRANS_ID_W = 3;
    // the bus addresses whole 64-bit words, so the byte offset bits are dropped
    localparam int unsigned WADDR_W    = ADDR_W - OFFSET_W;

    // --------------------
    // stage payloads
    // --------------------

    // issue to bus master, everything needed to run the bus cycle
    // and to realign the data afterwards
    typedef struct packed {
        logic [WADDR_W-1:0]    waddr;
        logic [XLEN_BYTES-1:0] sel;
        logic [OFFSET_W-1:0]   offset;
        ld_op_t                op;
        logic [TRANS_ID_W-1:0] trans_id;
    } mem_req_t;

    // bus master to align, the raw word plus what the extension step needs
    // the selects are no longer needed once the word is read
    typedef struct packed {
        logic [XLEN-1:0]       data;
        logic [OFFSET_W-1:0]   offset;
        ld_op_t                op;
        logic [TRANS_ID_W-1:0] trans_id;
    } mem_rsp_t;

endpackage

// ==== load_stage_reg.sv ====
// One-entry valid/ready pipeline register that carries an arbitrary payload type
`timescale 1ns/1ps

module load_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    // upstream side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    // downstream side
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     full_q;
    payload_t data_q;
    logic     push;

    // the entry can be refilled in the cycle it is drained, so a
    // back-to-back stream passes without bubbles
    assign in_ready_o = !full_q || out_ready_i;
    assign push       = in_valid_i && in_ready_o;

    // --------------------
    // full flag
    // --------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (push) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            // output taken and nothing new arrived
            full_q <= 1'b0;
        end
    end

    // --------------------
    // payload
    // --------------------

    // only written on a transfer, the flag above says whether it is meaningful
    always_ff @(posedge clk_i) begin
        if (push) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

// ==== load_issue.sv ====
// Load issue stage that stalls on a store page-offset match and forms word address and byte selects
`timescale 1ns/1ps

module load_issue import load_isa_pkg::*, load_unit_pkg::*; (
    // load request from the issue logic
    input  logic                     ld_valid_i,
    output logic                     ld_ready_o,
    input  ld_op_t                   ld_op_i,
    input  logic [ADDR_W-1:0]        ld_addr_i,
    input  logic [TRANS_ID_W-1:0]    ld_trans_id_i,
    // store hazard check
    output logic [PAGE_OFFSET_W-1:0] page_offset_o,
    input  logic                     page_offset_match_i,
    // towards the request stage register
    output logic                     req_valid_o,
    input  logic                     req_ready_i,
    output mem_req_t                 req_o
);

    logic [OFFSET_W-1:0] offset;
    logic                hazard;

    // --------------------
    // store hazard
    // --------------------

    // the store side compares only the page offset, so the load waits
    // whenever any pending store might alias it
    assign page_offset_o = ld_addr_i[PAGE_OFFSET_W-1:0];
    assign hazard        = page_offset_match_i;

    // both directions are gated so no transfer can slip through while the
    // match is high, whatever the downstream register is doing
    assign req_valid_o = ld_valid_i && !hazard;
    assign ld_ready_o  = req_ready_i && !hazard;

    // --------------------
    // address split
    // --------------------

    assign offset = ld_addr_i[OFFSET_W-1:0];

    always_comb begin
        // the bus sees only whole words
        req_o.waddr    = ld_addr_i[ADDR_W-1:OFFSET_W];
        // 1, 2, 4 or 8 lanes starting at the byte offset
        // loads are naturally aligned, so the mask never runs off the top lane
        req_o.sel      = ld_lane_mask(ld_op_i) << offset;
        // keep the offset for the realign step after the read
        req_o.offset   = offset;
        req_o.op       = ld_op_i;
        req_o.trans_id = ld_trans_id_i;
    end

endmodule

// ==== load_wb_master.sv ====
// Wishbone classic read master that runs one bus cycle per load and forwards the read word
`timescale 1ns/1ps

module load_wb_master import load_isa_pkg::*, load_unit_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // request from the request stage register
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  mem_req_t              req_i,
    // Wishbone classic read port
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic [WADDR_W-1:0]    wb_adr_o,
    output logic [XLEN_BYTES-1:0] wb_sel_o,
    input  logic [XLEN-1:0]       wb_dat_i,
    input  logic                  wb_ack_i,
    // response towards the response stage register
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output mem_rsp_t              rsp_o
);

    typedef enum logic {
        IDLE,
        BUS_ACTIVE
    } state_t;

    state_t state_q, state_d;
    // set for one cycle after an ack so cyc and stb stay low in between cycles
    logic   gap_q;
    logic   start;
    logic   done;

    // a cycle only starts when the response register can take the word, once
    // started that register stays free because nothing else writes it
    assign start = (state_q == IDLE) && !gap_q && req_valid_i && rsp_ready_i;

    // stb goes high in the same cycle the request shows up
    assign wb_stb_o = start || (state_q == BUS_ACTIVE);
    assign wb_cyc_o = wb_stb_o;
    assign done     = wb_stb_o && wb_ack_i;

    // address and selects come straight from the held request, which the
    // stage register keeps stable until it is popped on ack
    assign wb_adr_o = req_i.waddr;
    assign wb_sel_o = req_i.sel;

    // --------------------
    // completion
    // --------------------

    // pop the request and push the response on the ack edge
    assign req_ready_o    = done;
    assign rsp_valid_o    = done;
    assign rsp_o.data     = wb_dat_i;
    assign rsp_o.offset   = req_i.offset;
    assign rsp_o.op       = req_i.op;
    assign rsp_o.trans_id = req_i.trans_id;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // with zero wait states the cycle ends right where it begins
                if (start && !wb_ack_i) begin
                    state_d = BUS_ACTIVE;
                end
            end
            BUS_ACTIVE: begin
                if (wb_ack_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            gap_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            gap_q   <= done;
        end
    end

endmodule

// ==== load_align.sv ====
// Load align stage that shifts and extends the read word and holds the result for the consumer
`timescale 1ns/1ps

module load_align import load_isa_pkg::*, load_unit_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // response from the response stage register
    input  logic                  rsp_valid_i,
    output logic                  rsp_ready_o,
    input  mem_rsp_t              rsp_i,
    // result towards writeback
    output logic                  res_valid_o,
    input  logic                  res_ready_i,
    output logic [TRANS_ID_W-1:0] res_trans_id_o,
    output logic [XLEN-1:0]       res_data_o
);

    logic [XLEN-1:0]       shifted;
    logic [XLEN-1:0]       extended;
    logic                  sign_bit;
    logic                  res_valid_q;
    logic [XLEN-1:0]       res_data_q;
    logic [TRANS_ID_W-1:0] res_trans_id_q;
    logic                  take;

    // --------------------
    // realign and extend
    // --------------------

    // move the addressed bytes down to lane zero
    assign shifted = rsp_i.data >> {rsp_i.offset, 3'b000};

    // the sign comes from the top bit of the loaded field after the shift
    // and is forced to zero for the unsigned variants
    always_comb begin
        sign_bit = 1'b0;
        extended = shifted;
        case (rsp_i.op)
            LD_B, LD_BU: begin
                sign_bit = ld_is_signed(rsp_i.op) && shifted[7];
                extended = {{(XLEN - 8){sign_bit}}, shifted[7:0]};
            end
            LD_H, LD_HU: begin
                sign_bit = ld_is_signed(rsp_i.op) && shifted[15];
                extended = {{(XLEN - 16){sign_bit}}, shifted[15:0]};
            end
            LD_W, LD_WU: begin
                sign_bit = ld_is_signed(rsp_i.op) && shifted[31];
                extended = {{(XLEN - 32){sign_bit}}, shifted[31:0]};
            end
            // a doubleword is the whole word, offset is always zero here
            default: extended = shifted;
        endcase
    end

    // --------------------
    // result register
    // --------------------

    // a new result may replace one that is taken in the same cycle
    assign rsp_ready_o = !res_valid_q || res_ready_i;
    assign take        = rsp_valid_i && rsp_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_q <= 1'b0;
        end else if (take) begin
            res_valid_q <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    // held unchanged while the consumer stalls
    always_ff @(posedge clk_i) begin
        if (take) begin
            res_data_q     <= extended;
            res_trans_id_q <= rsp_i.trans_id;
        end
    end

    assign res_valid_o    = res_valid_q;
    assign res_data_o     = res_data_q;
    assign res_trans_id_o = res_trans_id_q;

endmodule

// ==== load_unit_top.sv ====
// Load unit top level that chains issue, request register, Wishbone master, response register and align
`timescale 1ns/1ps

module load_unit_top import load_isa_pkg::*, load_unit_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // load request
    input  logic                     ld_valid_i,
    output logic                     ld_ready_o,
    input  ld_op_t                   ld_op_i,
    input  logic [ADDR_W-1:0]        ld_addr_i,
    input  logic [TRANS_ID_W-1:0]    ld_trans_id_i,
    // store hazard check
    output logic [PAGE_OFFSET_W-1:0] page_offset_o,
    input  logic                     page_offset_match_i,
    // Wishbone classic read port
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic [WADDR_W-1:0]       wb_adr_o,
    output logic [XLEN_BYTES-1:0]    wb_sel_o,
    input  logic [XLEN-1:0]          wb_dat_i,
    input  logic                     wb_ack_i,
    // result
    output logic                     res_valid_o,
    input  logic                     res_ready_i,
    output logic [TRANS_ID_W-1:0]    res_trans_id_o,
    output logic [XLEN-1:0]          res_data_o
);

    // issue to request register
    logic     iss_valid, iss_ready;
    mem_req_t iss_req;
    // request register to bus master
    logic     req_valid, req_ready;
    mem_req_t req;
    // bus master to response register
    logic     bus_valid, bus_ready;
    mem_rsp_t bus_rsp;
    // response register to align
    logic     rsp_valid, rsp_ready;
    mem_rsp_t rsp;

    load_issue u_issue (
        .ld_valid_i, .ld_ready_o, .ld_op_i, .ld_addr_i, .ld_trans_id_i,
        .page_offset_o, .page_offset_match_i,
        .req_valid_o (iss_valid), .req_ready_i (iss_ready), .req_o (iss_req)
    );

    load_stage_reg #(.payload_t(mem_req_t)) u_req_reg (
        .clk_i, .rst_ni,
        .in_valid_i  (iss_valid), .in_ready_o  (iss_ready), .in_data_i  (iss_req),
        .out_valid_o (req_valid), .out_ready_i (req_ready), .out_data_o (req)
    );

    load_wb_master u_wb_master (
        .clk_i, .rst_ni,
        .req_valid_i (req_valid), .req_ready_o (req_ready), .req_i (req),
        .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_sel_o, .wb_dat_i, .wb_ack_i,
        .rsp_valid_o (bus_valid), .rsp_ready_i (bus_ready), .rsp_o (bus_rsp)
    );

    load_stage_reg #(.payload_t(mem_rsp_t)) u_rsp_reg (
        .clk_i, .rst_ni,
        .in_valid_i  (bus_valid), .in_ready_o  (bus_ready), .in_data_i  (bus_rsp),
        .out_valid_o (rsp_valid), .out_ready_i (rsp_ready), .out_data_o (rsp)
    );

    load_align u_align (
        .clk_i, .rst_ni,
        .rsp_valid_i (rsp_valid), .rsp_ready_o (rsp_ready), .rsp_i (rsp),
        .res_valid_o, .res_ready_i, .res_trans_id_o, .res_data_o
    );

endmodule

// ==== tb_load_unit_assert.sv ====
// Bound protocol checker for the Wishbone read port and the result handshake of the load unit
`timescale 1ns/1ps

module tb_load_unit_assert import load_isa_pkg::*, load_unit_pkg::*; (
    input logic                  clk_i,
    input logic                  rst_ni,
    // bus group, tied low in the align instance
    input logic                  cyc_i,
    input logic                  stb_i,
    input logic                  ack_i,
    input logic [WADDR_W-1:0]    adr_i,
    input logic [XLEN_BYTES-1:0] sel_i,
    // result group, tied low in the bus master instance
    input logic                  res_valid_i,
    input logic                  res_ready_i,
    input logic [XLEN-1:0]       res_data_i
);

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni) stb_i |-> cyc_i)
        else $error("wishbone stb high without cyc");

    // a cycle that is not yet acknowledged keeps its request unchanged
    stb_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stb_i && !ack_i |=> stb_i && $stable(adr_i) && $stable(sel_i))
        else $error("wishbone request changed before ack");

    // every acknowledged cycle is followed by at least one idle cycle
    bus_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stb_i && ack_i |=> !cyc_i && !stb_i)
        else $error("wishbone cycle did not drop after ack");

    res_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_data_i))
        else $error("result changed before it was accepted");

    idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !cyc_i && !stb_i && !res_valid_i)
        else $error("bus or result active during reset");

endmodule

bind load_wb_master tb_load_unit_assert u_bus_assert (
    .clk_i, .rst_ni, .cyc_i (wb_cyc_o), .stb_i (wb_stb_o), .ack_i (wb_ack_i),
    .adr_i (wb_adr_o), .sel_i (wb_sel_o),
    .res_valid_i (1'b0), .res_ready_i (1'b0), .res_data_i ('0)
);

bind load_align tb_load_unit_assert u_res_assert (
    .clk_i, .rst_ni, .cyc_i (1'b0), .stb_i (1'b0), .ack_i (1'b0), .adr_i ('0), .sel_i ('0),
    .res_valid_i (res_valid_o), .res_ready_i (res_ready_i), .res_data_i (res_data_o)
);

// ==== tb_load_unit.sv ====
// Testbench for the load unit with LFSR stimulus, a Wishbone memory model and a result scoreboard
`timescale 1ns/1ps

module tb_load_unit import load_isa_pkg::*, load_unit_pkg::*; ();

    localparam int NUM_LOADS   = 200;
    localparam int CLK_PERIOD  = 40;
    // window in which the consumer refuses every result
    localparam int STALL_START = 150;
    localparam int STALL_END   = 190;

    logic                     clk_i = 1'b0;
    logic                     rst_ni = 1'b0;
    logic                     ld_valid_i = 1'b0;
    logic                     ld_ready_o;
    ld_op_t                   ld_op_i = LD_D;
    logic [ADDR_W-1:0]        ld_addr_i = '0;
    logic [TRANS_ID_W-1:0]    ld_trans_id_i = '0;
    logic [PAGE_OFFSET_W-1:0] page_offset_o;
    logic                     page_offset_match_i = 1'b0;
    logic                     wb_cyc_o;
    logic                     wb_stb_o;
    logic [WADDR_W-1:0]       wb_adr_o;
    logic [XLEN_BYTES-1:0]    wb_sel_o;
    logic [XLEN-1:0]          wb_dat_i = '0;
    logic                     wb_ack_i = 1'b0;
    logic                     res_valid_o;
    logic                     res_ready_i = 1'b0;
    logic [TRANS_ID_W-1:0]    res_trans_id_o;
    logic [XLEN-1:0]          res_data_o;

    // model state, the memory covers address bits 6 to 3
    logic [31:0]           lfsr_q = 32'h7347;
    logic [XLEN-1:0]       mem [16];
    logic                  mem_filled = 1'b0;
    logic                  bus_busy = 1'b0;
    int                    wait_left = 0;
    int                    issued = 0;
    int                    res_count = 0;
    int                    errors = 0;
    int                    cycle = 0;
    logic                  held_valid = 1'b0;
    logic [XLEN-1:0]       held_data;
    logic [TRANS_ID_W-1:0] held_id;
    // one entry per accepted load, bus side and result side pop separately
    logic [XLEN-1:0]       exp_data_q [$];
    logic [TRANS_ID_W-1:0] exp_id_q [$];
    logic [WADDR_W-1:0]    exp_adr_q [$];
    logic [XLEN_BYTES-1:0] exp_sel_q [$];

    load_unit_top DUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // random numbers and reference model
    // --------------------

    // taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic int op_bytes(ld_op_t op);
        case (op)
            LD_B, LD_BU: return 1;
            LD_H, LD_HU: return 2;
            LD_W, LD_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic logic [XLEN_BYTES-1:0] lane_set(int nbytes, int off);
        logic [XLEN_BYTES-1:0] m;
        m = '0;
        for (int i = 0; i < nbytes; i++) m[off + i] = 1'b1;
        return m;
    endfunction

    // cut the field out of the word, then sign or zero fill above it
    function automatic logic [XLEN-1:0] expected_result(logic [XLEN-1:0] word, ld_op_t op, int off);
        logic [XLEN-1:0] val;
        logic [XLEN-1:0] keep;
        int              nbits;
        nbits = 8 * op_bytes(op);
        val   = word >> (8 * off);
        if (nbits < XLEN) begin
            keep = (64'd1 << nbits) - 64'd1;
            val  = val & keep;
            if ((op == LD_B || op == LD_H || op == LD_W) && val[nbits - 1]) val = val | ~keep;
        end
        return val;
    endfunction

    task automatic report_mismatch(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic report_problem(string what);
        $display("error: %s at %0t", what, $time);
        errors++;
    endtask

    // --------------------
    // per-edge model
    // --------------------

    task automatic fill_memory();
        logic [31:0] hi;
        logic [31:0] lo;
        for (int i = 0; i < 16; i++) begin
            hi = rand_bits(32);
            lo = rand_bits(32);
            mem[i] = {hi, lo};
        end
        mem_filled = 1'b1;
    endtask

    task automatic track_request();
        int off;
        if (page_offset_o != ld_addr_i[PAGE_OFFSET_W-1:0])
            report_mismatch("page_offset_o", 64'(page_offset_o), 64'(ld_addr_i[11:0]));
        if (page_offset_match_i && ld_ready_o)
            report_problem("ld_ready_o is high while page_offset_match_i is high");
        if (ld_valid_i && ld_ready_o) begin
            off = int'(ld_addr_i[OFFSET_W-1:0]);
            exp_data_q.push_back(expected_result(mem[ld_addr_i[6:3]], ld_op_i, off));
            exp_id_q.push_back(ld_trans_id_i);
            exp_adr_q.push_back(ld_addr_i[ADDR_W-1:OFFSET_W]);
            exp_sel_q.push_back(lane_set(op_bytes(ld_op_i), off));
        end
    endtask

    task automatic check_result();
        logic [XLEN-1:0]       exp_data;
        logic [TRANS_ID_W-1:0] exp_id;
        // a stalled result must not move
        if (held_valid) begin
            if (!res_valid_o) report_problem("res_valid_o dropped before the result was taken");
            if (res_data_o != held_data) report_mismatch("res_data_o", res_data_o, held_data);
            if (res_trans_id_o != held_id)
                report_mismatch("res_trans_id_o", 64'(res_trans_id_o), 64'(held_id));
        end
        held_valid = res_valid_o && !res_ready_i;
        held_data  = res_data_o;
        held_id    = res_trans_id_o;
        if (res_valid_o && res_ready_i) begin
            res_count++;
            if (exp_data_q.size() == 0) begin
                report_problem("result returned with no load outstanding");
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_id   = exp_id_q.pop_front();
                if (res_data_o != exp_data) report_mismatch("res_data_o", res_data_o, exp_data);
                if (res_trans_id_o != exp_id)
                    report_mismatch("res_trans_id_o", 64'(res_trans_id_o), 64'(exp_id));
            end
        end
    endtask

    task automatic serve_bus();
        logic [31:0] r;
        logic [WADDR_W-1:0] exp_adr;
        logic [XLEN_BYTES-1:0] exp_sel;
        if (wb_stb_o && wb_ack_i) begin
            // the cycle ends on this edge
            bus_busy = 1'b0;
            wb_ack_i <= 1'b0;
        end else if (wb_stb_o) begin
            if (!bus_busy) begin
                bus_busy  = 1'b1;
                r         = rand_bits(2);
                wait_left = int'(r[1:0]);
                if (exp_adr_q.size() == 0) begin
                    report_problem("bus cycle started with no load accepted");
                end else begin
                    exp_adr = exp_adr_q.pop_front();
                    exp_sel = exp_sel_q.pop_front();
                    if (wb_adr_o != exp_adr) report_mismatch("wb_adr_o", 64'(wb_adr_o), 64'(exp_adr));
                    if (wb_sel_o != exp_sel) report_mismatch("wb_sel_o", 64'(wb_sel_o), 64'(exp_sel));
                end
            end
            if (wait_left == 0) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[wb_adr_o[3:0]];
            end else begin
                wait_left--;
            end
        end
    endtask

    task automatic drive_request();
        logic [31:0] r;
        ld_op_t      op;
        int          off;
        // a pending request is held until it is taken
        if (!ld_valid_i || ld_ready_o) begin
            if (issued < NUM_LOADS && rand_bits(2) != 0) begin
                r = rand_bits(3);
                while (r == 7) r = rand_bits(3);
                op  = ld_op_t'(r[2:0]);
                r   = rand_bits(3);
                // natural alignment clears the low offset bits of wider loads
                off = int'(r[2:0]) & ~(op_bytes(op) - 1);
                r   = rand_bits(29);
                ld_valid_i    <= 1'b1;
                ld_op_i       <= op;
                ld_addr_i     <= {r[28:0], off[2:0]};
                ld_trans_id_i <= issued[TRANS_ID_W-1:0];
                issued++;
            end else begin
                ld_valid_i <= 1'b0;
            end
        end
    endtask

    task automatic drive_controls();
        logic [31:0] r;
        r = rand_bits(2);
        page_offset_match_i <= (r[1:0] == 2'd0);
        r = rand_bits(2);
        res_ready_i <= (r[1:0] != 2'd0) && !(cycle >= STALL_START && cycle < STALL_END);
        // after the long stall every stage is full and the input must be blocked
        if (cycle == STALL_END) begin
            if (ld_ready_o) report_problem("ld_ready_o still high after a long result stall");
            if (!res_valid_o) report_problem("no result held during the result stall");
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            if (!mem_filled) fill_memory();
        end else begin
            cycle++;
            track_request();
            check_result();
            serve_bus();
            drive_request();
            drive_controls();
        end
    end

    // --------------------
    // run control
    // --------------------

    initial begin
        int leftover;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        wait (res_count == NUM_LOADS);
        repeat (4) @(posedge clk_i);
        leftover = exp_data_q.size() + exp_adr_q.size();
        if (leftover != 0) $display("error: %0d accepted loads never completed", leftover);
        $display("loads %0d, results %0d, errors %0d", issued, res_count, errors + leftover);
        if (errors == 0 && leftover == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_LOADS * 20 * CLK_PERIOD);
        $display("timeout after %0d cycles with %0d of %0d results", cycle, res_count, NUM_LOADS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== build.f ====
load_isa_pkg.sv
load_unit_pkg.sv
load_stage_reg.sv
load_issue.sv
load_wb_master.sv
load_align.sv
load_unit_top.sv
tb_load_unit_assert.sv
tb_load_unit.sv

// ==== Makefile ====
# Verilator build and run of the load unit testbench
VERILATOR ?= verilator
TOP       ?= tb_load_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
